/* sources.f */
+incdir+include
logic/fft_data_pkg.sv
logic/fft_cfg_pkg.sv
logic/fft_twiddle_rom.sv
logic/fft_stage.sv
logic/fft_core.sv
logic/fft_cfg_regs.sv
logic/fft_top.sv
tests/fft_tb.sv

/* Bender.yml */
package:
  name: fft8

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/fft_data_pkg.sv
      - logic/fft_cfg_pkg.sv
      - logic/fft_twiddle_rom.sv
      - logic/fft_stage.sv
      - logic/fft_core.sv
      - logic/fft_cfg_regs.sv
      - logic/fft_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/fft_tb.sv

/* tests/fft_patterns.hex */
// four words per record: config (bit 4 inverse, bits 2:0 scale mask), input samples 7..0,
// expected bins 7..4 and expected bins 3..0, each bin as re then im.
// forward, all stages halve, impulse at sample 0
07
00000000000000000000000000000100
00200000002000000020000000200000
00200000002000000020000000200000
// forward, constant input
07
01000100010001000100010001000100
00000000000000000000000000000000
00000000000000000000000001000000
// forward, alternating signs
07
FF000100FF000100FF000100FF000100
00000000000000000000000001000000
00000000000000000000000000000000
// forward, impulse at sample 1
07
00000000000000000000000001000000
0017001700000020FFE90017FFE00000
FFE9FFE90000FFE00016FFE900200000
// inverse without scaling, impulse at sample 1
10
00000000000000000000000001000000
00B6FF4B0000FF00FF4BFF4BFF000000
FF4A00B50000010000B500B501000000
// inverse without scaling, short decaying ramp
10
00000000000000000008001000200040
0051FFD40030FFE80030FFF400280000
002F000C003000180050002C00780000

/* tests/fft_tb.sv */
`include "fft_consts.svh"

module fft_tb;

  localparam int NREC = 6;
  localparam int WORDS = 4; // config, input, bins 7..4, bins 3..0.
  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DLY = 10;
  localparam int TIMEOUT = 200;

  logic                      clk;
  logic                      rst_n;
  fft_data_pkg::real_frame_t in_frame;
  logic                      in_val;
  logic                      in_rdy;
  fft_data_pkg::cplx_frame_t out_frame;
  logic                      out_val;
  logic                      out_rdy;
  logic                      cfg_we;
  fft_cfg_pkg::cfg_addr_e    cfg_addr;
  logic [7:0]                cfg_wdata;
  logic [15:0]               cfg_rdata;

  logic [127:0]              pat_mem[NREC*WORDS];
  fft_data_pkg::cplx_frame_t exp_q[$];
  int                        tin_q[$]; // cycle of each input transfer.
  int                        gaps[NREC];
  logic [31:0]               lfsr_state = 32'he878_a26d;
  int                        cycle = 0;
  int                        checks = 0;
  int                        errors = 0;
  int                        n_sent = 0;
  int                        n_out = 0;
  logic                      lat_mode = 1'b0;
  logic                      bp_mode = 1'b0;

  fft_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_frame (in_frame),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .out_frame(out_frame),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // galois form with taps x^32 + x^22 + x^2 + x + 1.
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
  endfunction

  ////////////////////
  // output side
  ////////////////////

  initial begin
    out_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      if (bp_mode) begin
        out_rdy = lfsr_bit();
      end else begin
        out_rdy = 1'b1;
      end
    end
  end

  initial begin
    fft_data_pkg::cplx_frame_t want;
    int                        t_in;
    forever begin
      @(negedge clk);
      if (out_val && out_rdy) begin
        checks++;
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("an output frame arrived at time %0t with no frame in flight", $time);
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          t_in = tin_q.pop_front();
          checks++;
          assert (out_frame === want) else begin
            errors++;
            $display("FAIL %0t: frame %0d is %h, expected %h", $time, n_out, out_frame, want);
          end
          if (lat_mode) begin
            checks++;
            assert (cycle == t_in + `FFT_LOG2N) else begin
              errors++;
              $display("FAIL %0t: frame %0d took %0d cycles", $time, n_out, cycle - t_in);
            end
          end
        end
        n_out++;
      end
    end
  end

  ////////////////////
  // driver tasks
  ////////////////////

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("timed out at time %0t waiting for %s", $time, what);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic write_reg(input fft_cfg_pkg::cfg_addr_e addr, input logic [7:0] data);
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(posedge clk);
    #DRIVE_DLY;
    cfg_we = 1'b0;
  endtask

  task automatic check_reg(input fft_cfg_pkg::cfg_addr_e addr, input logic [15:0] want);
    cfg_addr = addr;
    @(negedge clk);
    checks++;
    assert (cfg_rdata === want) else begin
      errors++;
      $display("FAIL %0t: %s reads %h, expected %h", $time, addr.name(), cfg_rdata, want);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
    end
    if (exp_q.size() != 0) begin
      stop_on_timeout("the pipeline to drain");
    end
  endtask

  task automatic send_frame(input int rec, input int gap);
    int n;
    repeat (gap) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    in_frame = pat_mem[rec*WORDS+1];
    in_val = 1'b1;
    n = 0;
    @(negedge clk);
    while (!in_rdy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!in_rdy) begin
      stop_on_timeout("in_rdy");
    end else begin
      checks++;
      assert (!lat_mode || n == 0) else begin
        errors++;
        $display("FAIL %0t: in_rdy was low with out_rdy held high", $time);
      end
      exp_q.push_back({pat_mem[rec*WORDS+2], pat_mem[rec*WORDS+3]});
      tin_q.push_back(cycle); // the transfer completes on the edge that ends this cycle.
      n_sent++;
      @(posedge clk);
      #DRIVE_DLY;
      in_val = 1'b0;
    end
  endtask

  task automatic apply_config(input int rec);
    logic [127:0] w;
    w = pat_mem[rec*WORDS];
    write_reg(fft_cfg_pkg::CFG_CTRL, {7'd0, w[4]});
    write_reg(fft_cfg_pkg::CFG_SCALE, 8'(w[2:0]));
    check_reg(fft_cfg_pkg::CFG_CTRL, 16'(w[4]));
    check_reg(fft_cfg_pkg::CFG_SCALE, 16'(w[2:0]));
  endtask

  // the core only takes new settings while it is empty.
  task automatic run_records(input logic use_gaps);
    logic new_cfg;
    for (int i = 0; i < NREC; i++) begin
      new_cfg = (i == 0);
      if (i > 0) begin
        new_cfg = pat_mem[i*WORDS] != pat_mem[(i-1)*WORDS];
      end
      if (new_cfg) begin
        wait_drained();
        apply_config(i);
      end
      send_frame(i, use_gaps ? gaps[i] : 0);
    end
    wait_drained();
  endtask

  ////////////////////
  // sequence
  ////////////////////

  initial begin
    rst_n = 1'b0;
    in_frame = '0;
    in_val = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = fft_cfg_pkg::CFG_CTRL;
    cfg_wdata = '0;
    $readmemh("tests/fft_patterns.hex", pat_mem);
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    @(negedge clk);
    checks++;
    assert (!out_val && in_rdy) else begin
      errors++;
      $display("FAIL %0t: out_val %b, in_rdy %b after reset", $time, out_val, in_rdy);
    end
    @(posedge clk);
    #DRIVE_DLY;
    check_reg(fft_cfg_pkg::CFG_CTRL, 16'd0);
    check_reg(fft_cfg_pkg::CFG_SCALE, 16'((1 << `FFT_LOG2N) - 1));
    check_reg(fft_cfg_pkg::CFG_COUNT, 16'd0);

    lat_mode = 1'b1; // out_rdy stays high, so the latency is fixed.
    run_records(1'b0);
    lat_mode = 1'b0;

    for (int i = 0; i < NREC; i++) begin
      gaps[i] = lfsr_bit();
      gaps[i] = 2 * gaps[i] + lfsr_bit();
    end
    @(negedge clk);
    bp_mode = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    run_records(1'b1);
    @(negedge clk);
    bp_mode = 1'b0;
    @(posedge clk);
    #DRIVE_DLY;

    checks++;
    assert (n_out == n_sent && n_sent == 2 * NREC) else begin
      errors++;
      $display("FAIL %0t: %0d frames sent, %0d received", $time, n_sent, n_out);
    end
    check_reg(fft_cfg_pkg::CFG_COUNT, 16'(2 * NREC));
    write_reg(fft_cfg_pkg::CFG_COUNT, 8'h5a);
    check_reg(fft_cfg_pkg::CFG_COUNT, 16'(2 * NREC));

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* logic/fft_top.sv */
`include "fft_consts.svh"

module fft_top (
  input  logic                      clk,
  input  logic                      rst_n,

  input  fft_data_pkg::real_frame_t in_frame,
  input  logic                      in_val,
  output logic                      in_rdy,

  output fft_data_pkg::cplx_frame_t out_frame,
  output logic                      out_val,
  input  logic                      out_rdy,

  input  logic                      cfg_we,
  input  fft_cfg_pkg::cfg_addr_e    cfg_addr,
  input  logic [7:0]                cfg_wdata,
  output logic [15:0]               cfg_rdata
);

  fft_cfg_pkg::fft_cfg_t cfg;
  logic                  done;

  fft_cfg_regs cfg_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata),
    .done     (done),
    .cfg      (cfg)
  );

  fft_core core_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_frame (in_frame),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .out_frame(out_frame),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .cfg      (cfg),
    .done     (done)
  );

endmodule

/* logic/fft_cfg_regs.sv */
`include "fft_consts.svh"

module fft_cfg_regs (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     cfg_we,
  input  fft_cfg_pkg::cfg_addr_e   cfg_addr,
  input  logic [7:0]               cfg_wdata,
  output logic [15:0]              cfg_rdata,

  input  logic                     done,
  output fft_cfg_pkg::fft_cfg_t    cfg
);

  fft_cfg_pkg::fft_cfg_t cfg_q;
  logic [15:0]           count_q;

  ////////////////////
  // writable settings
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.inverse <= 1'b0;
      cfg_q.scale <= '1; // all stages halve, so no input can overflow.
    end else if (cfg_we) begin
      case (cfg_addr)
        fft_cfg_pkg::CFG_CTRL:  cfg_q.inverse <= cfg_wdata[0];
        fft_cfg_pkg::CFG_SCALE: cfg_q.scale <= cfg_wdata[`FFT_LOG2N-1:0];
        default: ; // the count is read only.
      endcase
    end
  end

  ////////////////////
  // frame counter
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (done) begin
      count_q <= count_q + 16'd1; // wraps at 2^16.
    end
  end

  always_comb begin
    case (cfg_addr)
      fft_cfg_pkg::CFG_CTRL:  cfg_rdata = {15'd0, cfg_q.inverse};
      fft_cfg_pkg::CFG_SCALE: cfg_rdata = 16'(cfg_q.scale);
      fft_cfg_pkg::CFG_COUNT: cfg_rdata = count_q;
      default:                cfg_rdata = '0;
    endcase
  end

  assign cfg = cfg_q;

  addr_known_on_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_we |-> !$isunknown(cfg_addr)
  );

endmodule

/* logic/fft_core.sv */
`include "fft_consts.svh"

module fft_core (
  input  logic                      clk,
  input  logic                      rst_n,

  input  fft_data_pkg::real_frame_t in_frame,
  input  logic                      in_val,
  output logic                      in_rdy,

  output fft_data_pkg::cplx_frame_t out_frame,
  output logic                      out_val,
  input  logic                      out_rdy,

  input  fft_cfg_pkg::fft_cfg_t     cfg,
  output logic                      done
);

  fft_data_pkg::cplx_frame_t               frames[`FFT_LOG2N+1]; // index s feeds stage s.
  logic                                    vals  [`FFT_LOG2N+1];
  logic                                    rdys  [`FFT_LOG2N+1];
  fft_data_pkg::cplx_frame_t               rev_frame;
  fft_data_pkg::twiddle_t [`FFT_N/2-1:0] tw;

  function automatic int bit_rev(int v);
    int r;
    r = 0;
    for (int b = 0; b < `FFT_LOG2N; b++) begin
      r = (r << 1) | ((v >> b) & 1);
    end
    return r;
  endfunction

  ////////////////////
  // input reordering
  ////////////////////

  always_comb begin
    for (int i = 0; i < `FFT_N; i++) begin
      rev_frame[i].re = in_frame[bit_rev(i)];
      rev_frame[i].im = '0; // real input only.
    end
  end

  assign frames[0] = rev_frame;
  assign vals[0] = in_val;
  assign in_rdy = rdys[0];

  fft_twiddle_rom twiddle_rom_i (
    .inverse(cfg.inverse),
    .tw     (tw)
  );

  ////////////////////
  // stage chain
  ////////////////////

  for (genvar s = 0; s < `FFT_LOG2N; s++) begin : g_stage
    fft_stage #(
      .STAGE(s)
    ) stage_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .recv_frame(frames[s]),
      .recv_val  (vals[s]),
      .recv_rdy  (rdys[s]),
      .send_frame(frames[s+1]),
      .send_val  (vals[s+1]),
      .send_rdy  (rdys[s+1]),
      .tw        (tw),
      .scale     (cfg.scale[s])
    );
  end

  assign out_frame = frames[`FFT_LOG2N];
  assign out_val = vals[`FFT_LOG2N];
  assign rdys[`FFT_LOG2N] = out_rdy;
  assign done = out_val && out_rdy; // one pulse per frame handed out.

endmodule

/* logic/fft_stage.sv */
`include "fft_consts.svh"

module fft_stage #(
  parameter int STAGE = 0
) (
  input  logic                                    clk,
  input  logic                                    rst_n,

  input  fft_data_pkg::cplx_frame_t               recv_frame,
  input  logic                                    recv_val,
  output logic                                    recv_rdy,

  output fft_data_pkg::cplx_frame_t               send_frame,
  output logic                                    send_val,
  input  logic                                    send_rdy,

  input  fft_data_pkg::twiddle_t [`FFT_N/2-1:0] tw,
  input  logic                                    scale
);

  localparam int SPAN = 1 << STAGE; // distance between the two legs of a butterfly.
  localparam int GROUP = 2 * SPAN;
  localparam int TW_STEP = `FFT_N / GROUP; // twiddle stride inside one group.
  localparam int PW = 2 * `FFT_W + 1; // holds a full product plus the carry of the sum.

  typedef logic signed [PW-1:0] wide_t;

  fft_data_pkg::cplx_frame_t bfly_frame;
  fft_data_pkg::cplx_frame_t frame_q;
  logic                      val_q;

  // optional halving, then truncation back to the sample width.
  function automatic fft_data_pkg::sample_t narrow(wide_t v, logic half);
    wide_t s;
    s = half ? (v >>> 1) : v;
    return s[`FFT_W-1:0];
  endfunction

  ////////////////////
  // butterflies
  ////////////////////

  always_comb begin
    int    top;
    int    bot;
    int    k;
    wide_t xr;
    wide_t xi;
    wide_t pr;
    wide_t pi;
    bfly_frame = '0;
    for (int b = 0; b < `FFT_N / 2; b++) begin
      top = (b / SPAN) * GROUP + (b % SPAN);
      bot = top + SPAN;
      k = (b % SPAN) * TW_STEP;
      xr = wide_t'(recv_frame[top].re);
      xi = wide_t'(recv_frame[top].im);
      pr = (wide_t'(recv_frame[bot].re) * wide_t'(tw[k].cos_v)
          - wide_t'(recv_frame[bot].im) * wide_t'(tw[k].sin_v)) >>> `FFT_TW_FRAC;
      pi = (wide_t'(recv_frame[bot].re) * wide_t'(tw[k].sin_v)
          + wide_t'(recv_frame[bot].im) * wide_t'(tw[k].cos_v)) >>> `FFT_TW_FRAC;
      bfly_frame[top].re = narrow(xr + pr, scale);
      bfly_frame[top].im = narrow(xi + pi, scale);
      bfly_frame[bot].re = narrow(xr - pr, scale);
      bfly_frame[bot].im = narrow(xi - pi, scale);
    end
  end

  ////////////////////
  // one-frame pipeline register
  ////////////////////

  assign recv_rdy = !val_q || send_rdy; // empty, or the held frame leaves this cycle.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_q <= 1'b0;
    end else if (recv_rdy) begin
      val_q <= recv_val;
    end
  end

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      frame_q <= bfly_frame;
    end
  end

  assign send_frame = frame_q;
  assign send_val = val_q;

  // a stalled frame must wait in place until the next stage takes it.
  stall_holds_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    send_val && !send_rdy |=> send_val && $stable(send_frame)
  );

endmodule

/* logic/fft_twiddle_rom.sv */
`include "fft_consts.svh"

module fft_twiddle_rom (
  input  logic                                    inverse,
  output fft_data_pkg::twiddle_t [`FFT_N/2-1:0] tw
);

  localparam real PI = 3.14159265358979323846;

  // forward twiddles, w_k = cos(2 pi k / N) - j sin(2 pi k / N).
  function automatic fft_data_pkg::twiddle_t [`FFT_N/2-1:0] build_table();
    fft_data_pkg::twiddle_t [`FFT_N/2-1:0] t;
    real                                    ang;
    real                                    one;
    one = 2.0 ** `FFT_TW_FRAC;
    for (int k = 0; k < `FFT_N / 2; k++) begin
      ang = 2.0 * PI * k / `FFT_N;
      t[k].cos_v = fft_data_pkg::sample_t'(int'($cos(ang) * one)); // rounded to nearest.
      t[k].sin_v = fft_data_pkg::sample_t'(int'(-$sin(ang) * one));
    end
    return t;
  endfunction

  localparam fft_data_pkg::twiddle_t [`FFT_N/2-1:0] TW_FWD = build_table();

  ////////////////////
  // direction select
  ////////////////////

  always_comb begin
    for (int k = 0; k < `FFT_N / 2; k++) begin
      tw[k].cos_v = TW_FWD[k].cos_v;
      tw[k].sin_v = inverse ? -TW_FWD[k].sin_v : TW_FWD[k].sin_v; // conjugate for the ifft.
    end
  end

endmodule

/* logic/fft_cfg_pkg.sv */
`include "fft_consts.svh"

package fft_cfg_pkg;

  ////////////////////
  // register map
  ////////////////////

  typedef enum logic [1:0] {
    CFG_CTRL  = 2'd0, // bit 0 selects the inverse transform.
    CFG_SCALE = 2'd1, // one halving bit per stage.
    CFG_COUNT = 2'd2 // completed frames, read only.
  } cfg_addr_e;

  ////////////////////
  // settings seen by the core
  ////////////////////

  typedef struct packed {
    logic                  inverse;
    logic [`FFT_LOG2N-1:0] scale; // bit s halves the outputs of stage s.
  } fft_cfg_t;

endpackage

/* logic/fft_data_pkg.sv */
`include "fft_consts.svh"

package fft_data_pkg;

  ////////////////////
  // scalar and complex samples
  ////////////////////

  typedef logic signed [`FFT_W-1:0] sample_t; // fixed point, FFT_FRAC fraction bits.

  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  ////////////////////
  // whole frames
  ////////////////////

  typedef sample_t [`FFT_N-1:0] real_frame_t; // element 0 is the first sample in time.

  typedef cplx_t [`FFT_N-1:0] cplx_frame_t; // element k is frequency bin k at the output.

  ////////////////////
  // twiddle factors
  ////////////////////

  // both terms use FFT_TW_FRAC fraction bits.
  typedef struct packed {
    sample_t cos_v;
    sample_t sin_v; // already carries the sign of the transform direction.
  } twiddle_t;

endpackage

/* include/fft_consts.svh */
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

////////////////////
// transform size
////////////////////

`define FFT_N 8 // points per frame.
`define FFT_LOG2N 3 // one butterfly stage per bit of the point index.

////////////////////
// number formats
////////////////////

`define FFT_W 16 // two's complement sample width.
`define FFT_FRAC 8 // fraction bits of a sample.
`define FFT_TW_FRAC 14 // fraction bits of a twiddle, so 1.0 is 16384.

`endif
